// File: rv_core.f
+incdir+sim
design/rv_core_pkg.sv
design/fetch_unit.sv
design/inst_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/result_unit.sv
design/rv_core.sv
sim/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module rv_core_tb -f rv_core.f || exit 1
out=$(./obj_dir/Vrv_core_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" && echo "simulation ok" || {
    echo "simulation failed"
    exit 1
}

// File: sim/rv_ref_model.svh
/* Random RV32I instruction source and architectural model of the core,
   included into the testbench module after its reset pc is declared. */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

int    seed = 32'h62b9332e;
word_t model_regs [32];
word_t model_pc;

function automatic word_t rand_word();
    return $random(seed);
endfunction

function automatic void model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    model_pc = reset_pc;
endfunction

// weighted mix of the kept formats, a few unknown opcodes
function automatic word_t gen_inst();
    word_t       r;
    word_t       t;
    int          pick;
    reg_addr_t   rd;
    reg_addr_t   rs2b;
    logic [2:0]  f3;
    logic [2:0]  bf3;
    logic [6:0]  hi;
    logic [6:0]  odd_opc;
    logic [12:0] boff;
    logic [20:0] joff;
    r    = rand_word();
    t    = rand_word();
    pick = int'(rand_word() % 32'd100);
    rd   = (r[7:5] == 3'd0) ? 5'd0 : r[4:0];  // x0 targets more often
    f3   = r[20:18];
    hi   = ((f3 == 3'd0 || f3 == 3'd5) && t[12]) ? 7'h20 : 7'h00;
    bf3  = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;  // skip the two unused compares
    rs2b = (t[14:13] == 2'd0) ? r[12:8] : r[17:13];  // same reg now and then
    boff = {t[11:0], 1'b0};
    joff = {t[19:0], 1'b0};
    case (t[1:0])
        2'd0:    odd_opc = 7'b0000011;  // load
        2'd1:    odd_opc = 7'b0100011;  // store
        2'd2:    odd_opc = 7'b1110011;  // system
        default: odd_opc = 7'b0001111;  // fence
    endcase
    if (pick < 30) begin
        return {hi, r[17:13], r[12:8], f3, rd, 7'b0110011};
    end else if (pick < 55) begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
            return {hi, t[4:0], r[12:8], f3, rd, 7'b0010011};  // shift by immediate
        end
        return {t[11:0], r[12:8], f3, rd, 7'b0010011};
    end else if (pick < 70) begin
        return {boff[12], boff[10:5], rs2b, r[12:8], bf3, boff[4:1], boff[11], 7'b1100011};
    end else if (pick < 78) begin
        return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
    end else if (pick < 84) begin
        return {t[11:0], r[12:8], 3'b000, rd, 7'b1100111};
    end else if (pick < 90) begin
        return {t[19:0], rd, 7'b0110111};
    end else if (pick < 96) begin
        return {t[19:0], rd, 7'b0010111};
    end
    return {t[31:7], odd_opc};
endfunction

// alt means sub for funct3 0 and arithmetic shift for funct3 5
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
        3'd0:    return alt ? x - y : x + y;
        3'd1:    return x << y[4:0];
        3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'd3:    return (x < y) ? 32'd1 : 32'd0;
        3'd4:    return x ^ y;
        3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6:    return x | y;
        default: return x & y;
    endcase
endfunction

// runs one instruction on the model state and gives the retire it expects
function automatic retire_t model_exec(input word_t w, output logic has_wb);
    word_t   a;
    word_t   b;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_j;
    word_t   res;
    logic    taken;
    retire_t r;
    a         = model_regs[w[19:15]];
    b         = model_regs[w[24:20]];
    imm_i     = {{20{w[31]}}, w[31:20]};
    imm_b     = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    res       = '0;
    taken     = 1'b0;
    has_wb    = 1'b1;
    r.pc      = model_pc;
    r.next_pc = model_pc + 32'd4;
    r.rd      = w[11:7];
    case (w[6:0])
        7'b0110011: res = alu_ref(w[14:12], w[30], a, b);
        7'b0010011: res = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
        7'b1100011: begin
            has_wb = 1'b0;
            case (w[14:12])
                3'd0:    taken = (a == b);
                3'd1:    taken = (a != b);
                3'd4:    taken = ($signed(a) < $signed(b));
                3'd5:    taken = ($signed(a) >= $signed(b));
                3'd6:    taken = (a < b);
                3'd7:    taken = (a >= b);
                default: taken = 1'b0;
            endcase
            if (taken) begin
                r.next_pc = model_pc + imm_b;
            end
        end
        7'b1101111: begin
            res       = model_pc + 32'd4;
            r.next_pc = model_pc + imm_j;
        end
        7'b1100111: begin
            res       = model_pc + 32'd4;
            r.next_pc = (a + imm_i) & ~32'd1;  // target from the old rs1
        end
        7'b0110111: res = {w[31:12], 12'h000};
        7'b0010111: res = model_pc + {w[31:12], 12'h000};
        default:    has_wb = 1'b0;  // no-op
    endcase
    r.wdata  = res;
    r.reg_we = has_wb && r.rd != 5'd0;
    if (r.reg_we) begin
        model_regs[r.rd] = res;
    end
    model_pc = r.next_pc;
    return r;
endfunction

`endif

// File: sim/rv_core_tb.sv
/* Testbench for rv_core: answers fetches with random instructions after a
   random delay and checks every retire against the reference model. */
module rv_core_tb import rv_core_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t reset_pc    = 32'h8000_0000;  // core default
    localparam int    num_retires = 2000;
    localparam int    cycle_limit = num_retires * 8;  // at most 6 cycles per instruction

    logic    clk = 1'b0;
    logic    reset;
    logic    inst_valid;
    word_t   inst;
    logic    fetch_req;
    word_t   fetch_pc;
    logic    retire_valid;
    retire_t retire;
    int      cycle_count = 0;

    `include "rv_ref_model.svh"

    rv_core rv_core_i (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp, input logic has_wb);
        retire_t seen;
        seen = got;
        if (!has_wb) begin
            seen.wdata = exp.wdata;  // data has no meaning without a writeback
        end
        if (seen !== exp) begin
            report_mismatch({$sformatf("retire pc %h next_pc %h rd %0d wdata %h we %b, ",
                                       got.pc, got.next_pc, got.rd, got.wdata, got.reg_we),
                             $sformatf("expected pc %h next_pc %h rd %0d wdata %h we %b",
                                       exp.pc, exp.next_pc, exp.rd, exp.wdata, exp.reg_we)});
        end
    endtask

    // both strobes low outside the request and retire cycle
    task automatic check_no_strobes();
        check_flag(fetch_req, 1'b0, "fetch_req");
        check_flag(retire_valid, 1'b0, "retire_valid");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the core stopped retiring, %0d cycles passed", cycle_count);
            stop_with_failure();
        end
    end

    initial begin
        retire_t expected;
        logic    expect_wb;
        logic    pending;
        word_t   w;
        int      reply_delay;
        reset      <= 1'b1;
        inst_valid <= 1'b0;
        inst       <= '0;
        model_reset();
        expected  = '0;
        expect_wb = 1'b0;
        pending   = 1'b0;
        repeat (2) @(posedge clk);
        check_no_strobes();  // nothing requested while in reset
        reset <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < num_retires; n++) begin
            // request cycle, also where the previous retire shows up
            check_flag(fetch_req, 1'b1, "fetch_req");
            check_word(fetch_pc, model_pc, "fetch_pc");
            check_flag(retire_valid, pending, "retire_valid with fetch_req");
            if (pending) begin
                check_retire(retire, expected, expect_wb);
            end
            w           = gen_inst();
            expected    = model_exec(w, expect_wb);
            pending     = 1'b1;
            reply_delay = int'(rand_word() % 32'd4);
            repeat (reply_delay) begin
                @(posedge clk);
                check_no_strobes();
            end
            inst_valid <= 1'b1;
            inst       <= w;
            @(posedge clk);
            check_no_strobes();
            inst_valid <= 1'b0;
            @(posedge clk);
            check_no_strobes();
            @(posedge clk);
        end
        check_flag(retire_valid, 1'b1, "retire_valid of the last instruction");
        check_retire(retire, expected, expect_wb);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: design/rv_core.sv
/* RV32I integer core top level. One instruction in flight: fetch, then a
   single execute cycle, with a retire record for each instruction. */
module rv_core import rv_core_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    inst_valid,
    input  word_t   inst,
    output logic    fetch_req,
    output word_t   fetch_pc,
    output logic    retire_valid,
    output retire_t retire
);

    inst_u    cur_inst;
    logic     exec_valid;
    decoded_t dec;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_result;
    word_t    link;
    word_t    next_pc;
    logic     reg_we;
    word_t    reg_wdata;

    // fetch_pc doubles as the pc of the executing instruction
    fetch_unit #(
        .reset_pc(reset_pc)
    ) fetch_unit_i (
        .clk       (clk),
        .reset     (reset),
        .inst_valid(inst_valid),
        .inst      (inst),
        .next_pc   (next_pc),
        .fetch_req (fetch_req),
        .pc        (fetch_pc),
        .cur_inst  (cur_inst),
        .exec_valid(exec_valid)
    );

    inst_decoder inst_decoder_i (
        .cur_inst(cur_inst),
        .dec     (dec)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .reset (reset),
        .we    (reg_we),
        .waddr (dec.rd),
        .wdata (reg_wdata),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .rdata1(rs1_val),
        .rdata2(rs2_val)
    );

    exec_unit exec_unit_i (
        .dec       (dec),
        .pc        (fetch_pc),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .alu_result(alu_result),
        .link      (link),
        .next_pc   (next_pc)
    );

    result_unit result_unit_i (
        .clk         (clk),
        .reset       (reset),
        .exec_valid  (exec_valid),
        .dec         (dec),
        .pc          (fetch_pc),
        .alu_result  (alu_result),
        .link        (link),
        .next_pc     (next_pc),
        .reg_we      (reg_we),
        .reg_wdata   (reg_wdata),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

endmodule

// File: design/result_unit.sv
/* Writeback select and register write strobe, plus the registered retire
   record that leaves the core one cycle after execute. */
module result_unit import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     exec_valid,
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    alu_result,
    input  word_t    link,
    input  word_t    next_pc,
    output logic     reg_we,
    output word_t    reg_wdata,
    output logic     retire_valid,
    output retire_t  retire
);

    always_comb begin
        case (dec.wb_sel)
            wb_alu:  reg_wdata = alu_result;
            wb_link: reg_wdata = link;
            default: reg_wdata = '0;  // nothing written
        endcase
    end

    assign reg_we = exec_valid && dec.wb_sel != wb_none && dec.rd != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            retire.pc      <= pc;
            retire.next_pc <= next_pc;
            retire.rd      <= dec.rd;
            retire.wdata   <= reg_wdata;
            retire.reg_we  <= reg_we;
        end
    end

endmodule

// File: design/exec_unit.sv
/* Execute stage: ALU operand select, the ALU itself, branch compares and
   the next pc. Purely combinational. */
module exec_unit import rv_core_pkg::*; (
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output word_t    alu_result,
    output word_t    link,
    output word_t    next_pc
);

    word_t      alu_a;
    word_t      alu_b;
    logic [4:0] shamt;
    word_t      branch_target;
    logic       taken;

    // operand a is rs1, pc or zero for lui
    always_comb begin
        if (dec.src_a_zero) begin
            alu_a = '0;
        end else if (dec.src_a_pc) begin
            alu_a = pc;
        end else begin
            alu_a = rs1_val;
        end
    end

    assign alu_b = dec.src_b_imm ? dec.imm : rs2_val;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_result = alu_a + alu_b;
            alu_sub:  alu_result = alu_a - alu_b;
            alu_sll:  alu_result = alu_a << shamt;
            alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            alu_xor:  alu_result = alu_a ^ alu_b;
            alu_srl:  alu_result = alu_a >> shamt;
            alu_sra:  alu_result = $signed(alu_a) >>> shamt;
            alu_or:   alu_result = alu_a | alu_b;
            alu_and:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // compares always on the register values
    always_comb begin
        case (dec.branch_f3)
            3'b000:  taken = (rs1_val == rs2_val);                    // beq
            3'b001:  taken = (rs1_val != rs2_val);                    // bne
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));   // blt
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));  // bge
            3'b110:  taken = (rs1_val < rs2_val);                     // bltu
            3'b111:  taken = (rs1_val >= rs2_val);                    // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign link          = pc + 32'd4;
    assign branch_target = pc + dec.imm;

    always_comb begin
        if (dec.is_branch && taken) begin
            next_pc = branch_target;
        end else if (dec.is_jal) begin
            next_pc = alu_result;
        end else if (dec.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else begin
            next_pc = link;
        end
    end

endmodule

// File: design/reg_file.sv
/* 32 x 32 integer register file: two combinational read ports and one
   write port. x0 reads as zero and never takes a write. */
module reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 hard-wired
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

// File: design/inst_decoder.sv
/* Combinational RV32I decoder. Picks the immediate through the union view
   of the format and produces the control word for execute and writeback. */
module inst_decoder import rv_core_pkg::*; (
    input  inst_u    cur_inst,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;  // sub / sra select
    alu_op_e    arith_op;

    assign opcode    = cur_inst.r_fmt.opcode;
    assign funct3    = cur_inst.r_fmt.funct3;
    assign funct7_b5 = cur_inst.r_fmt.funct7[5];

    // shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == opc_op && funct7_b5) begin
                    arith_op = alu_sub;  // no subi in the ISA
                end else begin
                    arith_op = alu_add;
                end
            end
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7_b5 ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        dec            = '0;
        dec.rd         = cur_inst.r_fmt.rd;
        dec.rs1        = cur_inst.r_fmt.rs1;
        dec.rs2        = cur_inst.r_fmt.rs2;
        dec.branch_f3  = cur_inst.b_fmt.funct3;
        dec.alu_op     = alu_add;
        dec.wb_sel     = wb_none;

        case (opcode)
            opc_op: begin
                dec.alu_op = arith_op;
                dec.wb_sel = wb_alu;
            end
            opc_op_imm: begin
                dec.imm       = {{20{cur_inst.i_fmt.imm12[11]}}, cur_inst.i_fmt.imm12};
                dec.alu_op    = arith_op;
                dec.src_b_imm = 1'b1;
                dec.wb_sel    = wb_alu;
            end
            opc_branch: begin
                dec.imm = {{20{cur_inst.b_fmt.imm12}}, cur_inst.b_fmt.imm11,
                           cur_inst.b_fmt.imm10_5, cur_inst.b_fmt.imm4_1, 1'b0};
                dec.is_branch = 1'b1;
            end
            opc_jal: begin
                dec.imm = {{12{cur_inst.j_fmt.imm20}}, cur_inst.j_fmt.imm19_12,
                           cur_inst.j_fmt.imm11, cur_inst.j_fmt.imm10_1, 1'b0};
                dec.src_a_pc  = 1'b1;  // target comes out of the alu
                dec.src_b_imm = 1'b1;
                dec.is_jal    = 1'b1;
                dec.wb_sel    = wb_link;
            end
            opc_jalr: begin
                dec.imm       = {{20{cur_inst.i_fmt.imm12[11]}}, cur_inst.i_fmt.imm12};
                dec.src_b_imm = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.wb_sel    = wb_link;
            end
            opc_lui: begin
                dec.imm        = {cur_inst.u_fmt.imm20, 12'b0};
                dec.src_a_zero = 1'b1;
                dec.src_b_imm  = 1'b1;
                dec.wb_sel     = wb_alu;
            end
            opc_auipc: begin
                dec.imm       = {cur_inst.u_fmt.imm20, 12'b0};
                dec.src_a_pc  = 1'b1;
                dec.src_b_imm = 1'b1;
                dec.wb_sel    = wb_alu;
            end
            default: ;  // unknown opcode, retires as a no-op
        endcase
    end

endmodule

// File: design/fetch_unit.sv
/* Holds the pc, issues one fetch request per instruction and captures the
   reply. exec_valid marks the single cycle in which the instruction runs. */
module fetch_unit import rv_core_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_valid,
    input  word_t inst,
    input  word_t next_pc,
    output logic  fetch_req,
    output word_t pc,
    output inst_u cur_inst,
    output logic  exec_valid
);

    typedef enum logic [1:0] {
        st_request,
        st_wait,
        st_exec
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_request;
        end else begin
            case (state)
                st_request: state <= st_wait;  // request lasts one cycle
                st_wait:    if (inst_valid) state <= st_exec;
                st_exec:    state <= st_request;
                default:    state <= st_request;
            endcase
        end
    end

    // pc moves on once the instruction has executed
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (state == st_exec) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait && inst_valid) begin
            cur_inst <= inst;
        end
    end

    assign fetch_req  = (state == st_request) && !reset;  // quiet while in reset
    assign exec_valid = (state == st_exec);

endmodule

// File: design/rv_core_pkg.sv
/* Shared types for the RV32I core: widths, opcodes, the instruction views,
   the decoded control word and the retire record. */
package rv_core_pkg;

    parameter int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // only the opcodes this core executes, anything else retires as a no-op
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_link  // pc+4
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // branch offset is scattered over both ends of the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;         // sign extended
        alu_op_e    alu_op;
        logic       src_a_pc;
        logic       src_a_zero;  // lui
        logic       src_b_imm;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] branch_f3;
        wb_sel_e    wb_sel;
    } decoded_t;

    typedef struct packed {
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rd;
        word_t     wdata;
        logic      reg_we;
    } retire_t;

endpackage
